// File: source/clint_consts.svh
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// ------------------------------------------------------------------------
// address map
// ------------------------------------------------------------------------

`define CLINT_BASE            32'h0200_0000
`define CLINT_SIZE            32'h0001_0000

// offsets are relative to the base and fit in 16 bits.
`define CLINT_MSIP_OFF        16'h0000
`define CLINT_MTIMECMP_LO_OFF 16'h4000
`define CLINT_MTIMECMP_HI_OFF 16'h4004
`define CLINT_MTIME_LO_OFF    16'hBFF8
`define CLINT_MTIME_HI_OFF    16'hBFFC

// ------------------------------------------------------------------------
// timer and reset values
// ------------------------------------------------------------------------

// clk cycles per mtime increment, any value of 1 or more.
`define CLINT_TICK_DIV        4

`define CLINT_MTIMECMP_RST    64'hFFFF_FFFF_FFFF_FFFF
`define CLINT_MTIME_RST       64'h0000_0000_0000_0000
`define CLINT_MSIP_RST        1'b0

`endif

// File: source/clint_pkg.sv
package clint_pkg;

    // ------------------------------------------------------------------------
    // AXI4-Lite channel payloads
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } axil_resp_e;

    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [31:0] data;
        axil_resp_e  resp;
    } axil_r_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // ------------------------------------------------------------------------
    // internal register access
    // ------------------------------------------------------------------------

    // one access per bus transaction; reads carry a zero strobe.
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        axil_resp_e  resp;
    } reg_rsp_t;

endpackage

// File: source/axil_slave_port.sv
`timescale 1ns/10ps

module axil_slave_port (
    input  logic                clk,
    input  logic                rst,

    input  clint_pkg::axil_ar_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,

    input  clint_pkg::axil_aw_t aw,
    input  logic                aw_valid,
    output logic                aw_ready,

    input  clint_pkg::axil_w_t  w,
    input  logic                w_valid,
    output logic                w_ready,

    output clint_pkg::axil_r_t  r,
    output logic                r_valid,
    input  logic                r_ready,

    output clint_pkg::axil_b_t  b,
    output logic                b_valid,
    input  logic                b_ready,

    output clint_pkg::reg_req_t req,
    output logic                req_valid,
    input  clint_pkg::reg_rsp_t rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_w,
        st_wait_aw,
        st_resp
    } state_e;

    state_e state;

    logic ar_fire;
    logic aw_fire;
    logic w_fire;

    // a pending read address blocks the write channels so that an aw or w
    // transfer is never taken and then dropped.
    assign ar_ready = (state == st_idle);
    assign aw_ready = ((state == st_idle) && !ar_valid) || (state == st_wait_aw);
    assign w_ready  = ((state == st_idle) && !ar_valid) || (state == st_wait_w);

    assign ar_fire = ar_valid && ar_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // ------------------------------------------------------------------------
    // handshake state machine
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            req_valid <= 1'b0;
            r_valid   <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (ar_fire) begin
                        req_valid <= 1'b1;
                        state     <= st_resp;
                    end else if (aw_fire && w_fire) begin
                        req_valid <= 1'b1;
                        state     <= st_resp;
                    end else if (aw_fire) begin
                        state <= st_wait_w;
                    end else if (w_fire) begin
                        state <= st_wait_aw;
                    end
                end
                st_wait_w: begin
                    if (w_fire) begin
                        req_valid <= 1'b1;
                        state     <= st_resp;
                    end
                end
                st_wait_aw: begin
                    if (aw_fire) begin
                        req_valid <= 1'b1;
                        state     <= st_resp;
                    end
                end
                st_resp: begin
                    // the register block answers in the strobe cycle.
                    if (req_valid) begin
                        if (req.write) begin
                            b_valid <= 1'b1;
                        end else begin
                            r_valid <= 1'b1;
                        end
                    end
                    if (r_valid && r_ready) begin
                        r_valid <= 1'b0;
                        state   <= st_idle;
                    end
                    if (b_valid && b_ready) begin
                        b_valid <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // captured request and response payloads
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            req.addr  <= ar.addr;
            req.write <= 1'b0;
            req.wdata <= '0;
            req.wstrb <= '0;
        end else begin
            if (aw_fire) begin
                req.addr  <= aw.addr;
                req.write <= 1'b1;
            end
            if (w_fire) begin
                req.wdata <= w.data;
                req.wstrb <= w.strb;
            end
        end

        if (req_valid) begin
            if (req.write) begin
                b.resp <= rsp.resp;
            end else begin
                r.data <= rsp.rdata;
                r.resp <= rsp.resp;
            end
        end
    end

endmodule

// File: source/clint_regs.sv
`timescale 1ns/10ps
`include "clint_consts.svh"

module clint_regs (
    input  logic                clk,
    input  logic                rst,

    input  clint_pkg::reg_req_t req,
    input  logic                req_valid,
    output clint_pkg::reg_rsp_t rsp,

    input  logic [63:0]         mtime,
    output logic                mtime_we_lo,
    output logic                mtime_we_hi,
    output logic [31:0]         mtime_wdata,
    output logic [63:0]         mtimecmp,
    output logic                msip
);

    logic [31:0] offset;
    logic [15:0] word_off;
    logic        in_window;
    logic        wr_en;

    logic        sel_msip;
    logic        sel_cmp_lo;
    logic        sel_cmp_hi;
    logic        sel_time_lo;
    logic        sel_time_hi;

    logic [31:0] read_word;

    // replaces the bytes of old_word whose strobe bit is set.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------

    assign offset    = req.addr - `CLINT_BASE;
    assign in_window = (offset < `CLINT_SIZE);

    // the byte lane bits do not take part in the decode.
    assign word_off = {offset[15:2], 2'b00};

    assign sel_msip    = in_window && (word_off == `CLINT_MSIP_OFF);
    assign sel_cmp_lo  = in_window && (word_off == `CLINT_MTIMECMP_LO_OFF);
    assign sel_cmp_hi  = in_window && (word_off == `CLINT_MTIMECMP_HI_OFF);
    assign sel_time_lo = in_window && (word_off == `CLINT_MTIME_LO_OFF);
    assign sel_time_hi = in_window && (word_off == `CLINT_MTIME_HI_OFF);

    assign wr_en = req_valid && req.write;

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------

    always_comb begin
        read_word = '0;
        if (sel_msip) begin
            read_word = {31'b0, msip};
        end else if (sel_cmp_lo) begin
            read_word = mtimecmp[31:0];
        end else if (sel_cmp_hi) begin
            read_word = mtimecmp[63:32];
        end else if (sel_time_lo) begin
            read_word = mtime[31:0];
        end else if (sel_time_hi) begin
            read_word = mtime[63:32];
        end
    end

    assign rsp.rdata = read_word;
    assign rsp.resp  = in_window ? clint_pkg::resp_okay : clint_pkg::resp_slverr;

    // ------------------------------------------------------------------------
    // msip and mtimecmp storage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msip     <= `CLINT_MSIP_RST;
            mtimecmp <= `CLINT_MTIMECMP_RST;
        end else if (wr_en) begin
            if (sel_msip && req.wstrb[0]) begin
                msip <= req.wdata[0];
            end
            if (sel_cmp_lo) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req.wdata, req.wstrb);
            end
            if (sel_cmp_hi) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req.wdata, req.wstrb);
            end
        end
    end

    // mtime lives in the counter, so the merge is done here against its
    // current half and the counter takes a whole word.
    assign mtime_we_lo = wr_en && sel_time_lo;
    assign mtime_we_hi = wr_en && sel_time_hi;
    assign mtime_wdata = merge_bytes(sel_time_hi ? mtime[63:32] : mtime[31:0],
                                     req.wdata, req.wstrb);

endmodule

// File: source/mtime_counter.sv
`timescale 1ns/10ps
`include "clint_consts.svh"

module mtime_counter (
    input  logic        clk,
    input  logic        rst,

    input  logic        we_lo,
    input  logic        we_hi,
    input  logic [31:0] wdata,
    input  logic [63:0] mtimecmp,

    output logic [63:0] mtime,
    output logic        mtip
);

    localparam int TICK_DIV = `CLINT_TICK_DIV;
    localparam int PW       = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc;
    logic          tick;

    assign tick = (presc == PW'(TICK_DIV - 1));

    // ------------------------------------------------------------------------
    // prescaler and counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc <= '0;
            mtime <= `CLINT_MTIME_RST;
        end else if (we_lo) begin
            // the high half holds and the tick phase starts over.
            mtime[31:0] <= wdata;
            presc       <= '0;
        end else if (we_hi) begin
            mtime[63:32] <= wdata;
            presc        <= '0;
        end else if (tick) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + PW'(1);
        end
    end

    // ------------------------------------------------------------------------
    // timer interrupt
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: source/clint_top.sv
`timescale 1ns/10ps

module clint_top (
    input  logic                clk,
    input  logic                rst,

    input  clint_pkg::axil_ar_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,

    input  clint_pkg::axil_aw_t aw,
    input  logic                aw_valid,
    output logic                aw_ready,

    input  clint_pkg::axil_w_t  w,
    input  logic                w_valid,
    output logic                w_ready,

    output clint_pkg::axil_r_t  r,
    output logic                r_valid,
    input  logic                r_ready,

    output clint_pkg::axil_b_t  b,
    output logic                b_valid,
    input  logic                b_ready,

    output logic                mtip,
    output logic                msip
);

    clint_pkg::reg_req_t req;
    clint_pkg::reg_rsp_t rsp;
    logic                req_valid;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] mtime_wdata;
    logic        mtime_we_lo;
    logic        mtime_we_hi;

    axil_slave_port axil_slave_port_inst (
        .clk       (clk),
        .rst       (rst),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp)
    );

    clint_regs clint_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .rsp         (rsp),
        .mtime       (mtime),
        .mtime_we_lo (mtime_we_lo),
        .mtime_we_hi (mtime_we_hi),
        .mtime_wdata (mtime_wdata),
        .mtimecmp    (mtimecmp),
        .msip        (msip)
    );

    mtime_counter mtime_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .we_lo    (mtime_we_lo),
        .we_hi    (mtime_we_hi),
        .wdata    (mtime_wdata),
        .mtimecmp (mtimecmp),
        .mtime    (mtime),
        .mtip     (mtip)
    );

endmodule

// File: tests/clint_sva.sv
`timescale 1ns/10ps

module clint_sva (
    input logic                clk,
    input logic                rst,
    input logic                ar_ready,
    input logic                aw_ready,
    input logic                w_ready,
    input clint_pkg::axil_r_t  r,
    input logic                r_valid,
    input logic                r_ready,
    input clint_pkg::axil_b_t  b,
    input logic                b_valid,
    input logic                b_ready,
    input logic [63:0]         mtime,
    input logic [63:0]         mtimecmp,
    input logic                mtip
);

    // a stalled response keeps its valid and its payload.
    r_hold: assert property (@(posedge clk) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else $error("r channel dropped or changed while stalled");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
        else $error("b channel dropped or changed while stalled");

    // no new access is taken while a response is pending.
    ready_low: assert property (@(posedge clk) disable iff (rst)
        (r_valid || b_valid) |-> (!ar_ready && !aw_ready && !w_ready))
        else $error("ready high while a response is pending");

    mtip_cmp: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (mtip == $past(mtime >= mtimecmp)))
        else $error("mtip does not follow the compare");

endmodule

bind clint_top clint_sva clint_sva_inst (
    .clk      (clk),
    .rst      (rst),
    .ar_ready (ar_ready),
    .aw_ready (aw_ready),
    .w_ready  (w_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .mtip     (mtip)
);

// File: tests/clint_tb.sv
`timescale 1ns/10ps
`include "clint_consts.svh"

module clint_tb;

    localparam logic [31:0] SEED    = 32'h8d06;
    localparam int          NUM_OPS = 200;
    localparam int          LIMIT   = 200 * NUM_OPS;

    // kinds of expected responses. the read kinds are numbered below K_WR.
    localparam int K_EXACT = 0;
    localparam int K_TIME  = 1;
    localparam int K_ANY   = 2;
    localparam int K_WR    = 3;
    localparam int K_WTIME = 4;

    logic clk = 1'b0;
    logic rst = 1'b1;
    clint_pkg::axil_ar_t ar;
    clint_pkg::axil_aw_t aw;
    clint_pkg::axil_w_t  w;
    clint_pkg::axil_r_t  r;
    clint_pkg::axil_b_t  b;
    logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic r_valid, r_ready, b_valid, b_ready, mtip, msip;

    logic [31:0] lfsr = SEED;
    logic        m_msip = 1'b0;
    logic [63:0] m_cmp = `CLINT_MTIMECMP_RST;
    int          exp_kind[$];
    logic [31:0] exp_data[$];
    logic [1:0]  exp_resp[$];
    logic [31:0] time_base = 32'd0;
    logic [31:0] last_lo = 32'd0;
    int          time_cyc = 0;
    int          cyc = 0;
    int          err_data = 0;
    int          err_resp = 0;
    int          err_other = 0;

    clint_top clint_top_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // reference register map
    // ------------------------------------------------------------------------

    function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [15:0] word_offset(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `CLINT_BASE;
        return {off[15:2], 2'b00};
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr - `CLINT_BASE) < `CLINT_SIZE;
    endfunction

    function automatic logic [31:0] expect_read(input logic [31:0] addr);
        if (!in_window(addr)) return 32'd0;
        case (word_offset(addr))
            `CLINT_MSIP_OFF:        return {31'd0, m_msip};
            `CLINT_MTIMECMP_LO_OFF: return m_cmp[31:0];
            `CLINT_MTIMECMP_HI_OFF: return m_cmp[63:32];
            default:                return 32'd0;
        endcase
    endfunction

    function automatic logic [1:0] expect_resp(input logic [31:0] addr);
        return in_window(addr) ? 2'd0 : 2'd2;
    endfunction

    // ------------------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------------------

    task automatic wait_resp(input logic is_write, output logic [31:0] data);
        repeat (int'(rand_bits(2))) @(negedge clk);
        if (is_write) b_ready = 1'b1;
        else r_ready = 1'b1;
        #1;
        while (!(is_write ? b_valid : r_valid)) begin
            @(negedge clk);
            #1;
        end
        data = r.data;
        @(negedge clk);
        r_ready = 1'b0;
        b_ready = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        logic [15:0] wo;
        wo = word_offset(addr);
        if (in_window(addr) && wo == `CLINT_MTIME_LO_OFF) exp_kind.push_back(K_TIME);
        else if (in_window(addr) && wo == `CLINT_MTIME_HI_OFF) exp_kind.push_back(K_ANY);
        else exp_kind.push_back(K_EXACT);
        exp_data.push_back(expect_read(addr));
        exp_resp.push_back(expect_resp(addr));
        @(negedge clk);
        ar.addr = addr;
        ar_valid = 1'b1;
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ar_valid = 1'b0;
        wait_resp(1'b0, data);
    endtask

    // mode 0 drives aw and w together, 1 aw first, 2 w first.
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int mode);
        logic aw_done, w_done, aw_go, w_go;
        logic [31:0] dummy;
        logic [15:0] wo;
        wo = word_offset(addr);
        aw_done = 1'b0;
        w_done = 1'b0;
        if (in_window(addr) && wo == `CLINT_MTIME_LO_OFF && strb == 4'hF)
            exp_kind.push_back(K_WTIME);
        else
            exp_kind.push_back(K_WR);
        exp_data.push_back(data);
        exp_resp.push_back(expect_resp(addr));
        if (in_window(addr)) begin
            if (wo == `CLINT_MSIP_OFF && strb[0]) m_msip = data[0];
            if (wo == `CLINT_MTIMECMP_LO_OFF) m_cmp[31:0] = strobe_merge(m_cmp[31:0], data, strb);
            if (wo == `CLINT_MTIMECMP_HI_OFF)
                m_cmp[63:32] = strobe_merge(m_cmp[63:32], data, strb);
        end
        @(negedge clk);
        aw.addr = addr;
        w.data = data;
        w.strb = strb;
        aw_valid = (mode != 2);
        w_valid = (mode != 1);
        while (!(aw_done && w_done)) begin
            #1;
            aw_go = aw_valid && aw_ready;
            w_go = w_valid && w_ready;
            @(negedge clk);
            if (aw_go) begin
                aw_valid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_go) begin
                w_valid = 1'b0;
                w_done = 1'b1;
            end
            if (aw_done && !w_done) w_valid = 1'b1;
            if (w_done && !aw_done) aw_valid = 1'b1;
        end
        wait_resp(1'b1, dummy);
    endtask

    // ------------------------------------------------------------------------
    // response checks
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        int          kind;
        logic [31:0] ed;
        logic [1:0]  er;
        if ((r_valid && r_ready) || (b_valid && b_ready)) begin
            if (exp_kind.size() == 0) begin
                $display("a response arrived with no access pending at %0t", $time);
                err_other++;
            end else begin
                kind = exp_kind.pop_front();
                ed = exp_data.pop_front();
                er = exp_resp.pop_front();
                if (r_valid != (kind < K_WR)) begin
                    $display("response on the wrong channel at %0t", $time);
                    err_other++;
                end
                if (r_valid && 2'(r.resp) != er) begin
                    $display("error at %0t: read resp %0d, expected %0d", $time, r.resp, er);
                    err_resp++;
                end
                if (b_valid && 2'(b.resp) != er) begin
                    $display("error at %0t: write resp %0d, expected %0d", $time, b.resp, er);
                    err_resp++;
                end
                if (r_valid && kind == K_EXACT && r.data != ed) begin
                    $display("error at %0t: read %h, expected %h", $time, r.data, ed);
                    err_data++;
                end
                if (r_valid && kind == K_TIME) begin
                    if (r.data < time_base || r.data < last_lo ||
                        r.data > time_base + 32'(cyc - time_cyc)) begin
                        $display("error at %0t: mtime low %h outside %h..%h", $time, r.data,
                                 time_base, time_base + 32'(cyc - time_cyc));
                        err_data++;
                    end
                    last_lo <= r.data;
                end
                if (b_valid && kind == K_WTIME) begin
                    time_base <= ed;
                    last_lo <= ed;
                    time_cyc <= cyc;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, want);
            err_data++;
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] d;
        logic [31:0] x;
        logic [31:0] addr;
        int          sel;
        int          n;
        ar = '0;
        aw = '0;
        w = '0;
        {ar_valid, aw_valid, w_valid, r_ready, b_ready} = 5'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_bit(msip, 1'b0, "msip after reset");
        check_bit(mtip, 1'b0, "mtip after reset");
        bus_read(`CLINT_BASE + 32'h4000, d);
        bus_read(`CLINT_BASE + 32'h4004, d);
        bus_read(`CLINT_BASE + 32'hBFF8, d);
        bus_read(`CLINT_BASE + 32'hBFF8, d);

        for (int i = 0; i < 24; i++) begin
            sel = int'(rand_bits(2) % 3);
            addr = `CLINT_BASE + ((sel == 0) ? 32'h0 : (sel == 1) ? 32'h4000 : 32'h4004);
            bus_write(addr, rand_bits(32), 4'(rand_bits(4)), int'(rand_bits(2) % 3));
            check_bit(msip, m_msip, "msip");
            bus_read(addr, d);
        end

        bus_write(`CLINT_BASE + 32'hBFF8, 32'h0012_3400, 4'hF, 0);
        bus_read(`CLINT_BASE + 32'hBFF8, d);
        bus_read(`CLINT_BASE + 32'hBFF8, d);
        bus_write(`CLINT_BASE + 32'hBFFC, 32'h0000_0005, 4'hF, 0);
        bus_write(`CLINT_BASE + 32'hBFF8, 32'hFFFF_FFF0, 4'hF, 1);
        repeat (100) @(negedge clk);
        bus_read(`CLINT_BASE + 32'hBFFC, d);
        if (d != 32'd6) begin
            $display("error at %0t: mtime high %h, expected 6 after carry", $time, d);
            err_data++;
        end

        bus_write(`CLINT_BASE + 32'hBFF8, 32'h1000_0000, 4'hF, 2);
        bus_write(`CLINT_BASE + 32'h4000, 32'hFFFF_FFFF, 4'hF, 0);
        bus_write(`CLINT_BASE + 32'h4004, 32'h0000_0006, 4'hF, 0);
        bus_read(`CLINT_BASE + 32'hBFF8, x);
        bus_write(`CLINT_BASE + 32'h4000, x + 32'd40, 4'hF, 0);
        repeat (2) @(negedge clk);
        check_bit(mtip, 1'b0, "mtip below compare");
        n = 0;
        d = x;
        while (d < x + 32'd40 && n < 100) begin
            bus_read(`CLINT_BASE + 32'hBFF8, d);
            n++;
        end
        repeat (2) @(negedge clk);
        check_bit(mtip, 1'b1, "mtip at compare");
        bus_write(`CLINT_BASE + 32'h4004, 32'h0000_0007, 4'hF, 1);
        repeat (2) @(negedge clk);
        check_bit(mtip, 1'b0, "mtip after raising compare");

        bus_read(`CLINT_BASE + `CLINT_SIZE, d);
        bus_read(32'h0100_0000, d);
        bus_write(`CLINT_BASE + `CLINT_SIZE + 32'h4000, 32'hDEAD_BEEF, 4'hF, 0);
        bus_write(32'h0100_0000, 32'h0000_0001, 4'hF, 2);
        bus_read(`CLINT_BASE + 32'h0100, d);
        bus_write(`CLINT_BASE + 32'h0100, 32'h1234_5678, 4'hF, 0);
        bus_read(`CLINT_BASE + 32'h4000, d);
        bus_read(`CLINT_BASE + 32'h0, d);

        for (int mode = 0; mode < 3; mode++) begin
            bus_write(`CLINT_BASE + 32'h4000, rand_bits(32), 4'hF, mode);
            bus_read(`CLINT_BASE + 32'h4000, d);
            bus_write(`CLINT_BASE + 32'h0, {31'd0, ~m_msip}, 4'h1, mode);
            check_bit(msip, m_msip, "msip");
        end

        repeat (4) @(negedge clk);
        if (exp_kind.size() != 0) begin
            $display("%0d accesses never got a response", exp_kind.size());
            err_other++;
        end
        $display("data errors %0d, resp errors %0d, other errors %0d",
                 err_data, err_resp, err_other);
        if (err_data == 0 && err_resp == 0 && err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/clint_pkg.sv
source/axil_slave_port.sv
source/clint_regs.sv
source/mtime_counter.sv
source/clint_top.sv
tests/clint_sva.sv
tests/clint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CLINT testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module clint_tb \
    -o clint_sim

output=$(./obj_dir/clint_sim)
echo "$output"

if echo "$output" | grep -q "TEST OK"; then
    exit 0
else
    exit 1
fi
